// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= trans_batch.f
TOP       ?= trans_batch_tb
RTL_TOP   ?= trans_batch
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

RTL_SRCS := $(shell grep '^hw/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/batch_ctrl.sv
`timescale 1ns/1ps

module batch_ctrl
   import trans_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   init,
   input  logic                   empty,
   output logic                   pop,
   output logic                   hash_start,
   output logic                   lookup,
   output logic                   wr_en,
   output logic [result_bits-1:0] wr_index,
   output logic                   busy
);

   typedef enum logic [2:0] {
      s_idle,
      s_pop,
      s_hash,
      s_lookup,
      s_write
   } state_t;

   state_t state;

   always_ff @(posedge clk)
   begin
      if (reset || init)
         state <= s_idle;
      else
      begin
         case (state)
            s_idle:   if (!empty) state <= s_pop;
            s_pop:    state <= s_hash;        // Queue head loads here
            s_hash:   state <= s_lookup;
            s_lookup: state <= s_write;
            s_write:  state <= s_idle;
            default:  state <= s_idle;
         endcase
      end
   end

   // Results land in arrival order, wrapping at the table size
   always_ff @(posedge clk)
   begin
      if (reset || init)
         wr_index <= '0;
      else if (wr_en)
         wr_index <= wr_index + 1'b1;
   end

   assign pop        = (state == s_pop);
   assign hash_start = (state == s_hash);
   assign lookup     = (state == s_lookup);
   assign wr_en      = (state == s_write);
   assign busy       = !empty || (state != s_idle);

endmodule

// File: hw/position_hash.sv
`timescale 1ns/1ps

module position_hash
   import trans_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   input  position_t pos,
   output probe_t    probe
);

   localparam int slices = board_bits / 32;

   logic [31:0] fold;

   // Stand-in for a Zobrist hash: XOR of all board slices plus the state bits
   always_comb
   begin
      fold = '0;
      for (int i = 0; i < slices; i++)
         fold = fold ^ pos.board[i*32 +: 32];
      fold = fold ^ {23'b0, pos.white_to_move, pos.castle_mask, pos.en_passant_col};
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         probe <= '0;
      else if (start)
      begin
         probe.index <= fold[index_bits-1:0];
         probe.tag   <= fold[31:32-tag_bits];  // Upper half is the tag
      end
   end

endmodule

// File: hw/position_queue.sv
`timescale 1ns/1ps

module position_queue
   import trans_pkg::*;
#(
   parameter int queue_depth = 16
)
(
   input  logic      clk,
   input  logic      reset,
   input  logic      init,
   input  logic      push_valid,
   output logic      push_ready,
   input  position_t push_data,
   input  logic      pop,
   output position_t head,
   output logic      empty
);

   localparam int ptr_bits   = $clog2(queue_depth);
   localparam int count_bits = $clog2(queue_depth + 1);

   position_t             mem [queue_depth];
   logic [ptr_bits-1:0]   wr_ptr;
   logic [ptr_bits-1:0]   rd_ptr;
   logic [count_bits-1:0] count;
   logic                  do_push;

   assign push_ready = (count != count_bits'(queue_depth));
   assign empty      = (count == '0);
   assign do_push    = push_valid && push_ready;

   always_ff @(posedge clk)
   begin
      if (reset || init)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == ptr_bits'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == ptr_bits'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_push && !pop)
            count <= count + 1'b1;
         else if (!do_push && pop)
            count <= count - 1'b1;
      end
   end

   // Storage and head register carry no reset
   always_ff @(posedge clk)
   begin
      if (do_push && !init)
         mem[wr_ptr] <= push_data;
      if (pop)
         head <= mem[rd_ptr];              // Head stays put until the next pop
   end

endmodule

// File: hw/result_table.sv
`timescale 1ns/1ps

module result_table
   import trans_pkg::*;
(
   input  logic                   clk,
   input  logic                   wr_en,
   input  logic [result_bits-1:0] wr_index,
   input  lookup_result_t         wr_data,
   input  logic [result_bits-1:0] rd_index,
   output lookup_result_t         rd_data
);

   lookup_result_t mem [max_results];

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_index] <= wr_data;
      rd_data <= mem[rd_index];            // One cycle read latency
   end

endmodule

// File: hw/trans_batch.sv
`timescale 1ns/1ps

module trans_batch
   import trans_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     init,
   input  logic                     board_valid,
   output logic                     board_ready,
   input  position_t                position,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  logic [apb_addr_bits-1:0] paddr,
   input  logic [31:0]              pwdata,
   output logic [31:0]              prdata,
   output logic                     pready,
   output logic                     pslverr,
   input  logic [result_bits-1:0]   result_index,
   output lookup_result_t           result,
   output logic [result_bits-1:0]   result_count,
   output logic                     busy
);

   position_t      head;
   logic           empty;
   logic           pop;
   logic           hash_start;
   probe_t         probe;
   logic           lookup;
   lookup_result_t lookup_res;
   logic           wr_en;

   position_queue u_queue (
      .clk        (clk),
      .reset      (reset),
      .init       (init),
      .push_valid (board_valid),
      .push_ready (board_ready),
      .push_data  (position),
      .pop        (pop),
      .head       (head),
      .empty      (empty)
   );

   position_hash u_hash (
      .clk   (clk),
      .reset (reset),
      .start (hash_start),
      .pos   (head),
      .probe (probe)
   );

   trans_store u_store (
      .clk     (clk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .lookup  (lookup),
      .probe   (probe),
      .result  (lookup_res)
   );

   // Write index doubles as the visible result count
   batch_ctrl u_ctrl (
      .clk        (clk),
      .reset      (reset),
      .init       (init),
      .empty      (empty),
      .pop        (pop),
      .hash_start (hash_start),
      .lookup     (lookup),
      .wr_en      (wr_en),
      .wr_index   (result_count),
      .busy       (busy)
   );

   result_table u_results (
      .clk      (clk),
      .wr_en    (wr_en),
      .wr_index (result_count),
      .wr_data  (lookup_res),
      .rd_index (result_index),
      .rd_data  (result)
   );

endmodule

// File: hw/trans_pkg.sv
package trans_pkg;

   localparam int board_bits    = 256;
   localparam int index_bits    = 6;
   localparam int table_entries = 64;
   localparam int tag_bits      = 16;
   localparam int eval_bits     = 16;
   localparam int nodes_bits    = 16;
   localparam int result_bits   = 5;
   localparam int max_results   = 32;
   localparam int apb_addr_bits = 12;

   typedef struct packed {
      logic [board_bits-1:0] board;          // 64 squares of 4 bits
      logic                  white_to_move;
      logic [3:0]            castle_mask;
      logic [3:0]            en_passant_col;
   } position_t;

   // Exactly 64 bits so it maps onto two APB words
   typedef struct packed {
      logic                  valid;
      logic [tag_bits-1:0]   tag;
      logic [eval_bits-1:0]  eval;
      logic [7:0]            depth;
      logic [1:0]            flag;
      logic [nodes_bits-1:0] nodes;
      logic                  capture;
      logic [3:0]            pad;
   } trans_entry_t;

   typedef union packed {
      trans_entry_t     entry;
      logic [1:0][31:0] halves;              // Index 0 is the low word
   } trans_word_u;

   typedef struct packed {
      logic [index_bits-1:0] index;
      logic [tag_bits-1:0]   tag;
   } probe_t;

   typedef struct packed {
      logic                  entry_valid;
      logic                  collision;
      logic [eval_bits-1:0]  eval;
      logic [7:0]            depth;
      logic [1:0]            flag;
      logic [nodes_bits-1:0] nodes;
      logic                  capture;
   } lookup_result_t;

endpackage

// File: hw/trans_store.sv
`timescale 1ns/1ps

module trans_store
   import trans_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  logic [apb_addr_bits-1:0] paddr,
   input  logic [31:0]              pwdata,
   output logic [31:0]              prdata,
   output logic                     pready,
   output logic                     pslverr,
   input  logic                     lookup,
   input  probe_t                   probe,
   output lookup_result_t           result
);

   trans_word_u           mem [table_entries];
   logic [index_bits-1:0] apb_index;
   logic                  apb_half;
   logic                  addr_ok;
   logic                  access;
   trans_entry_t          stored;
   logic                  tag_match;
   logic                  hit;

   // Eight bytes per entry, halves at offsets 0 and 4
   assign apb_index = paddr[index_bits+2:3];
   assign apb_half  = paddr[2];
   assign addr_ok   = (paddr < apb_addr_bits'(table_entries * 8));
   assign access    = psel && penable;

   assign pready  = 1'b1;                 // Zero wait states
   assign pslverr = access && !addr_ok;
   assign prdata  = addr_ok ? mem[apb_index].halves[apb_half] : 32'h0;

   always_ff @(posedge clk)
   begin
      if (access && pwrite && addr_ok)
         mem[apb_index].halves[apb_half] <= pwdata;
   end

   // Lookup side sees the same word as one entry
   assign stored    = mem[probe.index].entry;
   assign tag_match = (stored.tag == probe.tag);
   assign hit       = stored.valid && tag_match;

   always_ff @(posedge clk)
   begin
      if (reset)
         result <= '0;
      else if (lookup)
      begin
         result.entry_valid <= hit;
         result.collision   <= stored.valid && !tag_match;
         result.eval        <= hit ? stored.eval    : '0;
         result.depth       <= hit ? stored.depth   : '0;
         result.flag        <= hit ? stored.flag    : '0;
         result.nodes       <= hit ? stored.nodes   : '0;
         result.capture     <= hit ? stored.capture : 1'b0;
      end
   end

endmodule

// File: testbench/trans_batch_stim.txt
# W addr data err | R addr exp_data exp_err | P board wtm castle ep | B | I   (all hex)
# Q index exp_count entry_valid collision eval depth flag nodes capture     (all hex)
W 028 DEADBEEF 0
W 02C 0BADF00D 0
R 028 DEADBEEF 0
R 02C 0BADF00D 0
W 000 11112222 0
W 200 FFFFFFFF 1
R 200 00000000 1
R 000 11112222 0
R FFC 00000000 1
W 1B0 0543E810 0
W 1B4 891A0064 0
R 1B4 891A0064 0
P AAAA0000000000000000000000000000000000000000000000000000B89E0005 1 F 3
P 0000000000000000000000000000000000000000000000000000000056780005 1 F 3
P 0000000000000000000000000000000000000000000000000000000000000000 0 0 0
Q 00 03 1 0 00C8 0A 2 1F40 1
Q 01 03 0 1 0000 00 0 0000 0
Q 02 03 0 0 0000 00 0 0000 0
I
B
I
P AAAA0000000000000000000000000000000000000000000000000000B89E0005 1 F 3
Q 00 01 1 0 00C8 0A 2 1F40 1

// File: testbench/trans_batch_sva.sv
`timescale 1ns/1ps

module trans_batch_sva (
   input logic clk,
   input logic reset,
   input logic init,
   input logic pready,
   input logic pop,
   input logic empty,
   input logic lookup,
   input logic wr_en
);

   int unsigned fail_count = 0;           // Failed assertion attempts

   // Zero wait state slave
   pready_high: assert property (@(posedge clk) disable iff (reset) pready)
      else
      begin
         fail_count++;
         $error("APB pready went low");
      end

   pop_with_data: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
      else
      begin
         fail_count++;
         $error("Queue popped while empty");
      end

   write_after_lookup: assert property (@(posedge clk) disable iff (reset || init)
      lookup |=> wr_en)
      else
      begin
         fail_count++;
         $error("No result write one cycle after a lookup");
      end

   write_needs_lookup: assert property (@(posedge clk) disable iff (reset || init)
      wr_en |-> $past(lookup))
      else
      begin
         fail_count++;
         $error("Result write without a lookup one cycle earlier");
      end

endmodule

bind trans_batch trans_batch_sva u_sva (
   .clk    (clk),
   .reset  (reset),
   .init   (init),
   .pready (pready),
   .pop    (pop),
   .empty  (empty),
   .lookup (lookup),
   .wr_en  (wr_en)
);

// File: testbench/trans_batch_tb.sv
`timescale 1ns/1ps

module trans_batch_tb
   import trans_pkg::*;
();

   logic                     clk = 1'b0;
   logic                     reset;
   logic                     init;
   logic                     board_valid;
   logic                     board_ready;
   position_t                position_in;
   logic                     psel;
   logic                     penable;
   logic                     pwrite;
   logic [apb_addr_bits-1:0] paddr;
   logic [31:0]              pwdata;
   logic [31:0]              prdata;
   logic                     pready;
   logic                     pslverr;
   logic [result_bits-1:0]   result_index;
   lookup_result_t           result;
   logic [result_bits-1:0]   result_count;
   logic                     busy;

   string                    cmds[$];
   logic [63:0]              store_model [table_entries];   // Expected store contents
   int                       mismatches = 0;
   int                       failures = 0;
   int                       pushed = 0;                    // Accepted since last init
   logic                     saw_full = 1'b0;
   int unsigned              cycles = 0;
   int unsigned              cycle_limit = 100000;

   trans_batch uut (
      .clk          (clk),
      .reset        (reset),
      .init         (init),
      .board_valid  (board_valid),
      .board_ready  (board_ready),
      .position     (position_in),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .result_index (result_index),
      .result       (result),
      .result_count (result_count),
      .busy         (busy)
   );

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("Timeout: run still going after %0d cycles", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected)
      begin
         mismatches++;
         $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_err(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         mismatches++;
         $display("Mismatch in %s: expected pslverr %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic check_count(input string name, input logic [result_bits-1:0] expected,
                              input logic [result_bits-1:0] actual);
      if (actual !== expected)
      begin
         mismatches++;
         $display("Mismatch in %s: expected count %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic check_result(input string name, input lookup_result_t expected,
                               input lookup_result_t actual);
      if (actual !== expected)
      begin
         mismatches++;
         $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   // Eight 32-bit slices folded, state bits at the bottom
   function automatic probe_t hash_position(input position_t pos);
      logic [31:0] acc;
      probe_t      pr;
      acc = pos.board[31:0];
      for (int s = 1; s < 8; s++)
         acc ^= pos.board[s*32 +: 32];
      acc[8:0] ^= {pos.white_to_move, pos.castle_mask, pos.en_passant_col};
      pr.index = acc[5:0];
      pr.tag   = acc[31:16];
      return pr;
   endfunction

   function automatic lookup_result_t predict_result(input position_t pos);
      probe_t         pr;
      trans_entry_t   e;
      lookup_result_t r;
      pr = hash_position(pos);
      e  = store_model[pr.index];
      r  = '0;
      if (e.valid && e.tag == pr.tag)
      begin
         r.entry_valid = 1'b1;
         r.eval        = e.eval;
         r.depth       = e.depth;
         r.flag        = e.flag;
         r.nodes       = e.nodes;
         r.capture     = e.capture;
      end
      else if (e.valid)
         r.collision = 1'b1;            // Occupied by another position
      return r;
   endfunction

   function automatic position_t random_position();
      position_t   p;
      logic [31:0] r;
      for (int s = 0; s < 8; s++)
         p.board[s*32 +: 32] = $urandom;
      r = $urandom;
      p.white_to_move  = r[0];
      p.castle_mask    = r[7:4];
      p.en_passant_col = {1'b0, r[10:8]};
      return p;
   endfunction

   // Bit 31 follows addr[11], so fill words never set valid
   function automatic logic [31:0] fill_word(input logic [apb_addr_bits-1:0] addr);
      return {addr, 8'hc3, addr};
   endfunction

   function automatic void model_write(input logic [apb_addr_bits-1:0] addr,
                                       input logic [31:0] data);
      if (addr[2])
         store_model[addr[8:3]][63:32] = data;
      else
         store_model[addr[8:3]][31:0] = data;
   endfunction

   // Setup phase, access phase, then sample before releasing the bus
   task automatic apb_access(input logic write, input logic [apb_addr_bits-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      rdata   = prdata;
      err     = pslverr;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic push_position(input position_t pos);
      logic accepted;
      accepted    = 1'b0;
      board_valid = 1'b1;
      position_in = pos;
      while (!accepted)
      begin
         accepted = board_ready;        // Stable until the next rising edge
         if (!accepted)
            saw_full = 1'b1;
         @(negedge clk);
      end
      board_valid = 1'b0;
      pushed++;
   endtask

   task automatic wait_idle();
      while (busy)
         @(negedge clk);
   endtask

   task automatic read_result(input logic [result_bits-1:0] idx, output lookup_result_t got);
      result_index = idx;
      @(negedge clk);
      got = result;
   endtask

   task automatic pulse_init();
      init = 1'b1;
      @(negedge clk);
      init   = 1'b0;
      pushed = 0;
      check_count("init", '0, result_count);
   endtask

   task automatic fill_store();
      logic [apb_addr_bits-1:0] addr;
      logic [31:0]              rdata;
      logic                     err;
      for (int a = 0; a < table_entries * 2; a++)
      begin
         addr = apb_addr_bits'(a * 4);
         apb_access(1'b1, addr, fill_word(addr), rdata, err);
         check_err($sformatf("fill %03h", addr), 1'b0, err);
         model_write(addr, fill_word(addr));
      end
   endtask

   task automatic load_commands(output bit ok);
      int    fd;
      string line;
      fd = $fopen("testbench/trans_batch_stim.txt", "r");
      ok = (fd != 0);
      if (ok)
      begin
         while (!$feof(fd))
         begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) != 8'h23 &&
                line.getc(0) != 8'h0a && line.getc(0) != 8'h0d)
               cmds.push_back(line);
         end
         $fclose(fd);
      end
   endtask

   task automatic run_command(input string line);
      byte                      op;
      int                       items;
      logic [apb_addr_bits-1:0] addr;
      logic [31:0]              data;
      logic [31:0]              rdata;
      logic                     exp_err;
      logic                     err;
      logic [board_bits-1:0]    board_v;
      logic                     wtm_v;
      logic [3:0]               castle_v;
      logic [3:0]               ep_v;
      logic [result_bits-1:0]   idx;
      logic [result_bits-1:0]   exp_count;
      logic                     hit_v;
      logic                     col_v;
      logic [eval_bits-1:0]     eval_v;
      logic [7:0]               depth_v;
      logic [1:0]               flag_v;
      logic [nodes_bits-1:0]    nodes_v;
      logic                     cap_v;
      position_t                pos;
      lookup_result_t           expected;
      lookup_result_t           actual;
      lookup_result_t           expected_q[$];
      int                       base;
      op    = line.getc(0);
      items = 0;
      case (op)
         "W":
         begin
            items = $sscanf(line, "%c %h %h %h", op, addr, data, exp_err);
            apb_access(1'b1, addr, data, rdata, err);
            check_err($sformatf("W %03h", addr), exp_err, err);
            if (addr < apb_addr_bits'(512))
               model_write(addr, data);
            items = (items == 4) ? 1 : 0;
         end
         "R":
         begin
            items = $sscanf(line, "%c %h %h %h", op, addr, data, exp_err);
            apb_access(1'b0, addr, 32'h0, rdata, err);
            check_word($sformatf("R %03h", addr), data, rdata);
            check_err($sformatf("R %03h", addr), exp_err, err);
            items = (items == 4) ? 1 : 0;
         end
         "P":
         begin
            items = $sscanf(line, "%c %h %h %h %h", op, board_v, wtm_v, castle_v, ep_v);
            pos.board          = board_v;
            pos.white_to_move  = wtm_v;
            pos.castle_mask    = castle_v;
            pos.en_passant_col = ep_v;
            push_position(pos);
            items = (items == 5) ? 1 : 0;
         end
         "B":
         begin
            base     = pushed;
            saw_full = 1'b0;
            for (int k = 0; k < 20; k++)
            begin
               pos = random_position();
               expected_q.push_back(predict_result(pos));
               push_position(pos);
            end
            if (!board_ready)
               saw_full = 1'b1;
            if (!saw_full)
            begin
               failures++;
               $display("Error: board_ready never dropped during the burst");
            end
            wait_idle();
            check_count("burst count", result_bits'(pushed), result_count);
            for (int k = 0; k < 20; k++)
            begin
               read_result(result_bits'(base + k), actual);
               check_result($sformatf("burst %0d", k), expected_q[k], actual);
            end
            items = 1;
         end
         "Q":
         begin
            items = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h", op, idx, exp_count,
                            hit_v, col_v, eval_v, depth_v, flag_v, nodes_v, cap_v);
            expected.entry_valid = hit_v;
            expected.collision   = col_v;
            expected.eval        = eval_v;
            expected.depth       = depth_v;
            expected.flag        = flag_v;
            expected.nodes       = nodes_v;
            expected.capture     = cap_v;
            wait_idle();
            check_count($sformatf("Q %0d count", idx), exp_count, result_count);
            read_result(idx, actual);
            check_result($sformatf("Q %0d", idx), expected, actual);
            items = (items == 10) ? 1 : 0;
         end
         "I":
         begin
            pulse_init();
            items = 1;
         end
         default:
            items = 0;
      endcase
      if (items != 1)
      begin
         failures++;
         $display("Error: stimulus line could not be understood: %s", line);
      end
   endtask

   initial
   begin
      bit ok;
      reset        = 1'b1;
      init         = 1'b0;
      board_valid  = 1'b0;
      position_in  = '0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      result_index = '0;
      void'($urandom(32'ha985_e94d));
      load_commands(ok);
      if (!ok)
      begin
         $display("Error: stimulus file testbench/trans_batch_stim.txt could not be opened");
         $display("TEST FAILED");
         $finish;
      end
      else
      begin
         // Per command budget, burst drain, store fill and reset
         cycle_limit = cmds.size() * 40 + 20 * 5 * 2 + table_entries * 4 + 8;
         repeat (4) @(negedge clk);
         reset = 1'b0;
         check_count("reset", '0, result_count);
         if (busy !== 1'b0)
         begin
            failures++;
            $display("Error: busy is not low after reset");
         end
         fill_store();
         foreach (cmds[n])
            run_command(cmds[n]);
         $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                  mismatches, failures, uut.u_sva.fail_count);
         if (mismatches == 0 && failures == 0 && uut.u_sva.fail_count == 0)
            $display("TEST OK");
         else
            $display("TEST FAILED");
         $finish;
      end
   end

endmodule

// File: trans_batch.f
hw/trans_pkg.sv
hw/position_queue.sv
hw/position_hash.sv
hw/trans_store.sv
hw/batch_ctrl.sv
hw/result_table.sv
hw/trans_batch.sv
testbench/trans_batch_sva.sv
testbench/trans_batch_tb.sv
